/* hdl/memUnitPkg.sv */
`default_nettype none

package memUnitPkg;

   localparam int DATA_W     = 32;
   localparam int ADDR_W     = 10;
   // top bit picks configuration (1) or RAM (0)
   localparam int BUS_ADDR_W = ADDR_W + 1;
   localparam int CNT_W      = 6;
   localparam int STRB_W     = DATA_W / 8;

   // register map
   localparam int CFG_FIELDS   = 13;
   localparam int CFG_CTRL_IDX = 31;
   localparam int CFG_IDX_W    = 5;

   // word index of each field inside a port block, port B adds 16
   localparam logic [3:0] F_ITER    = 4'd0;
   localparam logic [3:0] F_PERIOD  = 4'd1;
   localparam logic [3:0] F_DUTY    = 4'd2;
   localparam logic [3:0] F_START   = 4'd3;
   localparam logic [3:0] F_SHIFT   = 4'd4;
   localparam logic [3:0] F_INCR    = 4'd5;
   localparam logic [3:0] F_DELAY   = 4'd6;
   localparam logic [3:0] F_ITER2   = 4'd7;
   localparam logic [3:0] F_SHIFT2  = 4'd8;
   localparam logic [3:0] F_INCR2   = 4'd9;
   localparam logic [3:0] F_REVERSE = 4'd10;
   localparam logic [3:0] F_EXT     = 4'd11;
   localparam logic [3:0] F_INWR    = 4'd12;

   typedef struct packed {
      logic [ADDR_W-1:0] iter;
      logic [CNT_W-1:0]  period;
      logic [CNT_W-1:0]  duty;
      logic [ADDR_W-1:0] start;
      logic [ADDR_W-1:0] shift;
      logic [ADDR_W-1:0] incr;
      logic [CNT_W-1:0]  delay;
      logic [ADDR_W-1:0] iter2;
      logic [ADDR_W-1:0] shift2;
      logic [ADDR_W-1:0] incr2;
      logic              reverse;
      logic              ext;
      logic              inWr;
   } addrGenCfg_t;

   // decoded host request for the RAM side
   typedef struct packed {
      logic              we;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
   } memReq_t;

endpackage

`default_nettype wire

/* hdl/addrGen.sv */
`timescale 1ns/1ps
`default_nettype none

module addrGen (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          run,
   input  memUnitPkg::addrGenCfg_t       cfg,
   output logic [memUnitPkg::ADDR_W-1:0] addr,
   output logic                          en,
   output logic                          done
);

   import memUnitPkg::*;

   logic              delaying;
   logic              active;
   logic [CNT_W-1:0]  delayCnt;
   logic [CNT_W-1:0]  perCnt;
   logic [ADDR_W-1:0] iterCnt;
   logic [ADDR_W-1:0] iter2Cnt;
   logic [ADDR_W-1:0] base;
   logic              lastPer;
   logic              lastIter;
   logic              lastIter2;
   logic [ADDR_W-1:0] nextBase;

   // a zero count behaves like a count of one
   assign lastPer   = ({1'b0, perCnt} + 1'b1) >= {1'b0, cfg.period};
   assign lastIter  = ({1'b0, iterCnt} + 1'b1) >= {1'b0, cfg.iter};
   assign lastIter2 = ({1'b0, iter2Cnt} + 1'b1) >= {1'b0, cfg.iter2};

   // outer step starts from the base register
   assign nextBase = base + cfg.incr2 + cfg.shift2;

   // enabled during the first duty cycles of each period
   assign en   = active && (perCnt < cfg.duty);
   assign done = !(active || delaying);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         delaying <= 1'b0;
         active   <= 1'b0;
         delayCnt <= '0;
         perCnt   <= '0;
         iterCnt  <= '0;
         iter2Cnt <= '0;
         addr     <= '0;
         base     <= '0;
      end else if (run) begin
         // zero delay goes straight to the first active cycle
         delaying <= (cfg.delay != '0);
         active   <= (cfg.delay == '0);
         delayCnt <= cfg.delay;
         perCnt   <= '0;
         iterCnt  <= '0;
         iter2Cnt <= '0;
         addr     <= cfg.start;
         base     <= cfg.start;
      end else if (delaying) begin
         delayCnt <= delayCnt - 1'b1;
         if (delayCnt == CNT_W'(1)) begin
            delaying <= 1'b0;
            active   <= 1'b1;
         end
      end else if (active) begin
         if (!lastPer) begin
            perCnt <= perCnt + 1'b1;
            if (en) begin
               addr <= addr + cfg.incr;
            end
         end else begin
            // last cycle of a period steps by shift instead of incr
            perCnt <= '0;
            if (!lastIter) begin
               iterCnt <= iterCnt + 1'b1;
               addr    <= addr + cfg.shift;
            end else begin
               iterCnt <= '0;
               base    <= nextBase;
               addr    <= nextBase;
               if (!lastIter2) begin
                  iter2Cnt <= iter2Cnt + 1'b1;
               end else begin
                  iter2Cnt <= '0;
                  active   <= 1'b0;
               end
            end
         end
      end
   end

   // enable never starts from idle without a run
   property enNotFromIdle;
      @(posedge clk) disable iff (rst) done && !run |=> !en;
   endproperty
   assert property (enNotFromIdle);

endmodule

`default_nettype wire

/* hdl/dualPortRam.sv */
`timescale 1ns/1ps
`default_nettype none

module dualPortRam (
   input  logic                          clk,
   input  logic                          enA,
   input  logic                          enB,
   input  logic                          weA,
   input  logic                          weB,
   input  logic [memUnitPkg::ADDR_W-1:0] addrA,
   input  logic [memUnitPkg::ADDR_W-1:0] addrB,
   input  logic [memUnitPkg::DATA_W-1:0] dinA,
   input  logic [memUnitPkg::DATA_W-1:0] dinB,
   output logic [memUnitPkg::DATA_W-1:0] doutA,
   output logic [memUnitPkg::DATA_W-1:0] doutB
);

   import memUnitPkg::*;

   logic [DATA_W-1:0] mem [0:(1 << ADDR_W)-1];

   // write-first on both ports
   always_ff @(posedge clk) begin
      if (enA) begin
         if (weA) begin
            mem[addrA] <= dinA;
         end
         doutA <= weA ? dinA : mem[addrA];
      end
      if (enB) begin
         if (weB) begin
            mem[addrB] <= dinB;
         end
         doutB <= weB ? dinB : mem[addrB];
      end
   end

   // colliding writes would leave the word undefined
   assert property (@(posedge clk) !(enA && weA && enB && weB && addrA == addrB));

endmodule

`default_nettype wire

/* hdl/memUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module memUnit (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          run,
   output logic                          done,
   input  memUnitPkg::memReq_t           req,
   input  logic                          reqValid,
   output logic                          reqReady,
   output logic [memUnitPkg::DATA_W-1:0] rdata,
   input  logic [memUnitPkg::DATA_W-1:0] in0,
   input  logic [memUnitPkg::DATA_W-1:0] in1,
   output logic [memUnitPkg::DATA_W-1:0] out0,
   output logic [memUnitPkg::DATA_W-1:0] out1,
   input  memUnitPkg::addrGenCfg_t       cfgA,
   input  memUnitPkg::addrGenCfg_t       cfgB
);

   import memUnitPkg::*;

   logic [ADDR_W-1:0] genAddrA;
   logic [ADDR_W-1:0] genAddrB;
   logic              genEnA;
   logic              genEnB;
   logic              doneA;
   logic              doneB;
   logic              pending;
   logic              busA;
   logic [2:0]        readyPipe;
   logic [ADDR_W-1:0] addrA;
   logic [ADDR_W-1:0] addrB;
   logic              enA;
   logic              weA;
   logic              weB;
   logic [DATA_W-1:0] dinA;
   logic [ADDR_W-1:0] addrAReg;
   logic [ADDR_W-1:0] addrBReg;
   logic [DATA_W-1:0] dinAReg;
   logic [DATA_W-1:0] dinBReg;
   logic              enAReg;
   logic              enBReg;
   logic              weAReg;
   logic              weBReg;
   logic [DATA_W-1:0] doutA;
   logic [DATA_W-1:0] doutB;
   logic [DATA_W-1:0] outAReg;
   logic [DATA_W-1:0] outBReg;

   // FFT-style ordering
   function automatic logic [ADDR_W-1:0] reverseBits(input logic [ADDR_W-1:0] a);
      logic [ADDR_W-1:0] r;
      for (int i = 0; i < ADDR_W; i++) begin
         r[i] = a[ADDR_W-1-i];
      end
      return r;
   endfunction

   // stream address from the external input or the generator
   function automatic logic [ADDR_W-1:0] streamAddr(input addrGenCfg_t c,
                                                    input logic [DATA_W-1:0] s,
                                                    input logic [ADDR_W-1:0] g);
      if (c.ext) begin
         return s[ADDR_W-1:0];
      end
      return c.reverse ? reverseBits(g) : g;
   endfunction

   addrGen i_addrGenA (
      .clk(clk), .rst(rst), .run(run), .cfg(cfgA),
      .addr(genAddrA), .en(genEnA), .done(doneA)
   );

   addrGen i_addrGenB (
      .clk(clk), .rst(rst), .run(run), .cfg(cfgB),
      .addr(genAddrB), .en(genEnB), .done(doneB)
   );

   assign done = doneA & doneB;

   // bus takes port A on its accepting cycle only
   assign busA  = reqValid && !pending;
   assign addrA = busA ? req.addr : streamAddr(cfgA, in0, genAddrA);
   assign addrB = streamAddr(cfgB, in1, genAddrB);
   assign enA   = busA || genEnA;
   assign weA   = busA ? req.we : (genEnA && cfgA.inWr && !cfgA.ext);
   assign weB   = genEnB && cfgB.inWr && !cfgB.ext;
   assign dinA  = busA ? req.wdata : in0;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         enAReg    <= 1'b0;
         enBReg    <= 1'b0;
         weAReg    <= 1'b0;
         weBReg    <= 1'b0;
         pending   <= 1'b0;
         readyPipe <= '0;
      end else begin
         enAReg <= enA;
         enBReg <= genEnB;
         weAReg <= weA;
         weBReg <= weB;
         // reads enter at bit 2 and writes at bit 0
         readyPipe <= {busA && !req.we, readyPipe[2], readyPipe[1] | (busA && req.we)};
         if (busA) begin
            pending <= 1'b1;
         end else if (reqReady) begin
            pending <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      addrAReg <= addrA;
      addrBReg <= addrB;
      dinAReg  <= dinA;
      dinBReg  <= in1;
      outAReg  <= doutA;
      outBReg  <= doutB;
   end

   dualPortRam i_dualPortRam (
      .clk(clk), .enA(enAReg), .enB(enBReg), .weA(weAReg), .weB(weBReg),
      .addrA(addrAReg), .addrB(addrBReg), .dinA(dinAReg), .dinB(dinBReg),
      .doutA(doutA), .doutB(doutB)
   );

   assign reqReady = readyPipe[0];
   assign rdata    = reqReady ? outAReg : '0;
   assign out0     = outAReg;
   assign out1     = outBReg;

   assert property (@(posedge clk) disable iff (rst) reqReady |=> !reqReady);

endmodule

`default_nettype wire

/* hdl/configBank.sv */
`timescale 1ns/1ps
`default_nettype none

module configBank (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             wrEn,
   input  logic [memUnitPkg::CFG_IDX_W-1:0] idx,
   input  logic [memUnitPkg::DATA_W-1:0]    wdata,
   output logic [memUnitPkg::DATA_W-1:0]    rdataCfg,
   input  logic                             done,
   output logic                             run,
   output memUnitPkg::addrGenCfg_t          cfgA,
   output memUnitPkg::addrGenCfg_t          cfgB
);

   import memUnitPkg::*;

   logic [3:0]  field;
   logic        selB;
   logic        isCtrl;
   addrGenCfg_t rdCfg;

   function automatic addrGenCfg_t setField(input addrGenCfg_t c, input logic [3:0] k,
                                            input logic [DATA_W-1:0] d);
      addrGenCfg_t r;
      r = c;
      case (k)
         F_ITER:    r.iter    = d[ADDR_W-1:0];
         F_PERIOD:  r.period  = d[CNT_W-1:0];
         F_DUTY:    r.duty    = d[CNT_W-1:0];
         F_START:   r.start   = d[ADDR_W-1:0];
         F_SHIFT:   r.shift   = d[ADDR_W-1:0];
         F_INCR:    r.incr    = d[ADDR_W-1:0];
         F_DELAY:   r.delay   = d[CNT_W-1:0];
         F_ITER2:   r.iter2   = d[ADDR_W-1:0];
         F_SHIFT2:  r.shift2  = d[ADDR_W-1:0];
         F_INCR2:   r.incr2   = d[ADDR_W-1:0];
         F_REVERSE: r.reverse = d[0];
         F_EXT:     r.ext     = d[0];
         F_INWR:    r.inWr    = d[0];
         default:   r = c;
      endcase
      return r;
   endfunction

   // zero-extended readback of one field
   function automatic logic [DATA_W-1:0] getField(input addrGenCfg_t c, input logic [3:0] k);
      case (k)
         F_ITER:    return DATA_W'(c.iter);
         F_PERIOD:  return DATA_W'(c.period);
         F_DUTY:    return DATA_W'(c.duty);
         F_START:   return DATA_W'(c.start);
         F_SHIFT:   return DATA_W'(c.shift);
         F_INCR:    return DATA_W'(c.incr);
         F_DELAY:   return DATA_W'(c.delay);
         F_ITER2:   return DATA_W'(c.iter2);
         F_SHIFT2:  return DATA_W'(c.shift2);
         F_INCR2:   return DATA_W'(c.incr2);
         F_REVERSE: return DATA_W'(c.reverse);
         F_EXT:     return DATA_W'(c.ext);
         F_INWR:    return DATA_W'(c.inWr);
         default:   return '0;
      endcase
   endfunction

   // bit 4 selects port B
   assign field  = idx[3:0];
   assign selB   = idx[CFG_IDX_W-1];
   assign isCtrl = (idx == CFG_IDX_W'(CFG_CTRL_IDX));
   assign rdCfg  = selB ? cfgB : cfgA;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cfgA <= '0;
         cfgB <= '0;
         run  <= 1'b0;
      end else begin
         run <= wrEn && isCtrl && wdata[0];
         if (wrEn && !isCtrl) begin
            if (selB) begin
               cfgB <= setField(cfgB, field, wdata);
            end else begin
               cfgA <= setField(cfgA, field, wdata);
            end
         end
      end
   end

   always_comb begin
      if (isCtrl) begin
         rdataCfg = DATA_W'(done);
      end else if (field < CFG_FIELDS) begin
         rdataCfg = getField(rdCfg, field);
      end else begin
         rdataCfg = '0;
      end
   end

endmodule

`default_nettype wire

/* hdl/memSubsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module memSubsystem (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              valid,
   input  logic [memUnitPkg::STRB_W-1:0]     wstrb,
   input  logic [memUnitPkg::BUS_ADDR_W-1:0] addr,
   input  logic [memUnitPkg::DATA_W-1:0]     wdata,
   output logic                              ready,
   output logic [memUnitPkg::DATA_W-1:0]     rdata,
   input  logic [memUnitPkg::DATA_W-1:0]     in0,
   input  logic [memUnitPkg::DATA_W-1:0]     in1,
   output logic [memUnitPkg::DATA_W-1:0]     out0,
   output logic [memUnitPkg::DATA_W-1:0]     out1
);

   import memUnitPkg::*;

   logic              isCfg;
   logic              we;
   logic              memValid;
   logic              memReady;
   logic              cfgValid;
   logic              cfgReady;
   logic              cfgWrEn;
   logic              run;
   logic              done;
   logic [DATA_W-1:0] memRdata;
   logic [DATA_W-1:0] cfgRdata;
   memReq_t           req;
   addrGenCfg_t       cfgA;
   addrGenCfg_t       cfgB;

   // any strobe bit makes a full-word write
   assign we       = |wstrb;
   assign isCfg    = addr[BUS_ADDR_W-1];
   assign memValid = valid && !isCfg;
   assign cfgValid = valid && isCfg;
   assign req      = '{we: we, addr: addr[ADDR_W-1:0], wdata: wdata};

   // config write happens once, on the accepting cycle
   assign cfgWrEn = cfgValid && !cfgReady && we;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cfgReady <= 1'b0;
      end else begin
         cfgReady <= cfgValid && !cfgReady;
      end
   end

   configBank i_configBank (
      .clk(clk), .rst(rst), .wrEn(cfgWrEn), .idx(addr[CFG_IDX_W-1:0]),
      .wdata(wdata), .rdataCfg(cfgRdata), .done(done), .run(run),
      .cfgA(cfgA), .cfgB(cfgB)
   );

   memUnit i_memUnit (
      .clk(clk), .rst(rst), .run(run), .done(done), .req(req),
      .reqValid(memValid), .reqReady(memReady), .rdata(memRdata),
      .in0(in0), .in1(in1), .out0(out0), .out1(out1), .cfgA(cfgA), .cfgB(cfgB)
   );

   // memUnit already zeroes its rdata outside ready
   assign ready = cfgReady | memReady;
   assign rdata = (cfgReady ? cfgRdata : '0) | memRdata;

endmodule

`default_nettype wire

/* verification/memSubsystemTb.sv */
`timescale 1ns/1ps
`default_nettype none

module memSubsystemTb;

   import memUnitPkg::*;

   // the tests take under 3000 cycles
   localparam int TIMEOUT = 20000;
   localparam logic [4:0] CTRL = 5'(CFG_CTRL_IDX);

   logic                  clk;
   logic                  rst;
   logic                  valid;
   logic [STRB_W-1:0]     wstrb;
   logic [BUS_ADDR_W-1:0] addr;
   logic [DATA_W-1:0]     wdata;
   logic                  ready;
   logic [DATA_W-1:0]     rdata;
   logic [DATA_W-1:0]     in0;
   logic [DATA_W-1:0]     in1;
   logic [DATA_W-1:0]     out0;
   logic [DATA_W-1:0]     out1;

   int                valErr;
   int                otherErr;
   int                cyc;
   int                outChecks;
   int                bMode;
   logic [31:0]       dataSeed;
   logic [31:0]       streamSeed;
   logic [DATA_W-1:0] model [0:(1 << ADDR_W)-1];
   logic [DATA_W-1:0] inHist [0:TIMEOUT];
   logic [DATA_W-1:0] in1Hist [0:TIMEOUT];
   logic [ADDR_W-1:0] expAddr [int];
   logic [ADDR_W-1:0] expAddrA [int];
   int                wrCyc [$];
   logic [ADDR_W-1:0] wrAddr [$];
   addrGenCfg_t       cA;
   addrGenCfg_t       cB;

   memSubsystem i_memSubsystem (
      .clk(clk), .rst(rst), .valid(valid), .wstrb(wstrb), .addr(addr), .wdata(wdata),
      .ready(ready), .rdata(rdata), .in0(in0), .in1(in1), .out0(out0), .out1(out1)
   );

   function automatic logic [31:0] nextRand(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // first bit in ends up at the top
   function automatic logic [ADDR_W-1:0] bitRev(input logic [ADDR_W-1:0] a);
      logic [ADDR_W-1:0] r;
      r = '0;
      for (int i = 0; i < ADDR_W; i++) begin
         r = {r[ADDR_W-2:0], a[i]};
      end
      return r;
   endfunction

   task automatic checkVal(input string sig, input logic [31:0] exp, input logic [31:0] act);
      assert (exp === act) else begin
         valErr++;
         $display("ERR t=%0t %s expected %h actual %h", $time, sig, exp, act);
      end
   endtask

   always #2 clk = ~clk;

   // new stream words every cycle with a history per cycle index
   always @(posedge clk) begin
      streamSeed = nextRand(streamSeed);
      in0 <= streamSeed;
      inHist[cyc] = streamSeed;
      streamSeed = nextRand(streamSeed);
      in1 <= streamSeed & 32'hffff_fc3f;
      in1Hist[cyc] = streamSeed & 32'hffff_fc3f;
      cyc = cyc + 1;
      if (cyc >= TIMEOUT) begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT);
         $display("errors: value %0d other %0d", valErr, otherErr + 1);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   // out0 and out1 show the word of the address used three cycles earlier
   always @(negedge clk) begin
      int k;
      logic [ADDR_W-1:0] a;
      k = cyc - 1;
      if (!rst && expAddrA.exists(k)) begin
         outChecks++;
         checkVal("out0", model[expAddrA[k]], out0);
      end
      if (!rst && expAddr.exists(k)) begin
         if (bMode == 2) begin
            a = in1Hist[k-3][ADDR_W-1:0];
         end else if (bMode == 1) begin
            a = bitRev(expAddr[k]);
         end else begin
            a = expAddr[k];
         end
         outChecks++;
         checkVal("out1", model[a], out1);
      end
   end

   assert property (@(posedge clk) disable iff (rst) !ready |-> rdata == '0) else begin
      valErr++;
      $display("ERR t=%0t rdata expected %h actual %h", $time, 32'h0, rdata);
   end

   assert property (@(posedge clk) disable iff (rst) ready |=> !ready) else begin
      otherErr++;
      $display("ready stayed high for two cycles at t=%0t", $time);
   end

   task automatic busAccess(input logic we, input logic [BUS_ADDR_W-1:0] a,
                            input logic [DATA_W-1:0] d, output logic [DATA_W-1:0] rd,
                            output int lat, output int startCyc);
      @(negedge clk);
      startCyc = cyc;
      @(posedge clk);
      valid <= 1'b1;
      wstrb <= we ? '1 : '0;
      addr  <= a;
      wdata <= d;
      lat = 0;
      do begin
         @(negedge clk);
         lat++;
      end while (!ready && lat < 16);
      if (!ready) begin
         otherErr++;
         $display("bus access to %h never got ready", a);
      end
      rd = rdata;
      lat = lat - 1;
      @(posedge clk);
      valid <= 1'b0;
      wstrb <= '0;
   endtask

   task automatic memWrite(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
      logic [DATA_W-1:0] rd;
      int lat;
      int sc;
      busAccess(1'b1, {1'b0, a}, d, rd, lat, sc);
      checkVal("write ready latency", 1, lat);
      model[a] = d;
   endtask

   task automatic memRead(input logic [ADDR_W-1:0] a);
      logic [DATA_W-1:0] rd;
      int lat;
      int sc;
      busAccess(1'b0, {1'b0, a}, '0, rd, lat, sc);
      checkVal("read ready latency", 3, lat);
      checkVal("rdata", model[a], rd);
   endtask

   task automatic cfgAccess(input logic we, input logic [4:0] idx, input logic [DATA_W-1:0] d,
                            output logic [DATA_W-1:0] rd, output int startCyc);
      int lat;
      busAccess(we, {1'b1, 5'd0, idx}, d, rd, lat, startCyc);
      checkVal("config ready latency", 1, lat);
   endtask

   task automatic writeCfg(input logic [4:0] baseIdx, input addrGenCfg_t c);
      logic [DATA_W-1:0] vals [CFG_FIELDS];
      logic [DATA_W-1:0] rd;
      int sc;
      vals = '{32'(c.iter), 32'(c.period), 32'(c.duty), 32'(c.start), 32'(c.shift),
               32'(c.incr), 32'(c.delay), 32'(c.iter2), 32'(c.shift2), 32'(c.incr2),
               32'(c.reverse), 32'(c.ext), 32'(c.inWr)};
      for (int k = 0; k < CFG_FIELDS; k++) begin
         cfgAccess(1'b1, baseIdx + 5'(k), vals[k], rd, sc);
         cfgAccess(1'b0, baseIdx + 5'(k), '0, rd, sc);
         checkVal("config readback", vals[k], rd);
      end
   endtask

   // addresses and cycles straight from the loop rule
   task automatic schedule(input addrGenCfg_t c, input int runCyc, input bit isWrite,
                           input bit isB, output int finish);
      int it;
      int per;
      int it2;
      int t;
      logic [ADDR_W-1:0] a;
      it  = (c.iter == 0) ? 1 : int'(c.iter);
      per = (c.period == 0) ? 1 : int'(c.period);
      it2 = (c.iter2 == 0) ? 1 : int'(c.iter2);
      for (int o = 0; o < it2; o++) begin
         for (int i = 0; i < it; i++) begin
            for (int k = 0; k < int'(c.duty) && k < per; k++) begin
               a = ADDR_W'(int'(c.start) + o * (int'(c.incr2) + int'(c.shift2))
                   + i * (int'(c.duty) * int'(c.incr) + int'(c.shift)) + k * int'(c.incr));
               t = runCyc + int'(c.delay) + 1 + (o * it + i) * per + k;
               if (isWrite) begin
                  wrCyc.push_back(t);
                  wrAddr.push_back(a);
               end else if (isB) begin
                  expAddr[t+3] = a;
               end else begin
                  expAddrA[t+3] = a;
               end
            end
         end
      end
      finish = runCyc + int'(c.delay) + 1 + it2 * it * per;
   endtask

   task automatic runStreams();
      logic [DATA_W-1:0] rd;
      int sc;
      int runCyc;
      int finA;
      int finB;
      int fin;
      int tries;
      int expChecks;
      int startChecks;
      writeCfg(5'd0, cA);
      writeCfg(5'd16, cB);
      expAddr.delete();
      expAddrA.delete();
      wrCyc.delete();
      wrAddr.delete();
      startChecks = outChecks;
      cfgAccess(1'b1, CTRL, 32'h1, rd, sc);
      runCyc = sc + 1;
      schedule(cA, runCyc, cA.inWr && !cA.ext, 1'b0, finA);
      schedule(cB, runCyc, cB.inWr && !cB.ext, 1'b1, finB);
      expChecks = expAddr.num() + expAddrA.num();
      fin = (finA > finB) ? finA : finB;
      tries = 0;
      do begin
         cfgAccess(1'b0, CTRL, '0, rd, sc);
         checkVal("done", 32'(sc + 1 >= fin), rd);
         tries++;
      end while (rd[0] !== 1'b1 && tries < 200);
      repeat (4) @(negedge clk);
      if (outChecks - startChecks != expChecks) begin
         otherErr++;
         $display("stream outputs were checked %0d times instead of %0d",
                  outChecks - startChecks, expChecks);
      end
      for (int j = 0; j < wrCyc.size(); j++) begin
         model[wrAddr[j]] = inHist[wrCyc[j]];
      end
   endtask

   initial begin
      logic [DATA_W-1:0] rd;
      int sc;
      clk = 1'b0;
      rst = 1'b1;
      valid = 1'b0;
      wstrb = '0;
      addr = '0;
      wdata = '0;
      in0 = '0;
      in1 = '0;
      cyc = 0;
      valErr = 0;
      otherErr = 0;
      outChecks = 0;
      bMode = 0;
      dataSeed = 32'h61a01727;
      streamSeed = 32'h61a01727;
      repeat (16) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      checkVal("ready", 0, 32'(ready));
      cfgAccess(1'b0, CTRL, '0, rd, sc);
      checkVal("done after reset", 1, rd);

      // low 64 words hold random data for the read tests
      for (int i = 0; i < 64; i++) begin
         dataSeed = nextRand(dataSeed);
         memWrite(ADDR_W'(i), dataSeed);
      end
      for (int i = 0; i < 64; i++) begin
         memRead(ADDR_W'(i));
      end

      // port A writes in0 into 64..101
      cA = '0;
      cA.iter = 4;
      cA.period = 5;
      cA.duty = 3;
      cA.start = 64;
      cA.shift = 2;
      cA.incr = 1;
      cA.delay = 3;
      cA.iter2 = 2;
      cA.shift2 = 4;
      cA.incr2 = 16;
      cA.inWr = 1'b1;
      cB = '0;
      runStreams();
      for (int j = 0; j < wrAddr.size(); j++) begin
         memRead(wrAddr[j]);
      end

      // port A now reads its words back on out0
      cA.inWr = 1'b0;
      cB.iter = 8;
      cB.period = 3;
      cB.duty = 2;
      cB.start = 0;
      cB.shift = 1;
      cB.incr = 1;
      cB.delay = 2;
      cB.iter2 = 2;
      cB.shift2 = 2;
      cB.incr2 = 30;
      bMode = 0;
      runStreams();

      // multiples of 16 reverse into the low 64 words
      cB.iter = 4;
      cB.shift = 16;
      cB.incr = 16;
      cB.shift2 = 64;
      cB.incr2 = 64;
      cB.reverse = 1'b1;
      bMode = 1;
      runStreams();

      cB.reverse = 1'b0;
      cB.ext = 1'b1;
      bMode = 2;
      runStreams();

      $display("errors: value %0d other %0d", valErr, otherErr);
      if (valErr == 0 && otherErr == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* memSubsystem.f */
hdl/memUnitPkg.sv
hdl/addrGen.sv
hdl/dualPortRam.sv
hdl/memUnit.sv
hdl/configBank.sv
hdl/memSubsystem.sv
verification/memSubsystemTb.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the memSubsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module memSubsystemTb -f memSubsystem.f -o simv
if [ $? -ne 0 ]; then
   echo "compile failed"
   exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "PASS: all tests" <<< "$out"; then
   exit 0
else
   exit 1
fi
